//--- hdl/usb_line_pkg.sv
// ########################################
// usb line package.
// pad structs, line state codes and the bit
// timing constants shared by both ports.
// ########################################

`default_nettype none

package usb_line_pkg;

	// the core serves two downstream ports.
	localparam int num_ports = 2;

	// bit periods in usb_clk cycles, full speed and low speed.
	localparam int fs_bit_cycles = 4;
	localparam int ls_bit_cycles = 32;
	localparam int bit_timer_width = $clog2(ls_bit_cycles);

	// consecutive se0 cycles before a port is reported as disconnected.
	localparam int discon_limit = 127;
	localparam int discon_width = 7;

	// the receiver is blanked this many cycles after the transmit enable.
	localparam int rx_blank_cycles = 4;

	typedef logic [bit_timer_width-1:0] bit_timer_t;
	typedef logic [discon_width-1:0] discon_cnt_t;

	// line state as {vm, vp}, named after the full speed polarity.
	typedef enum logic [1:0] {se0 = 2'd0, j_fs = 2'd1, k_fs = 2'd2, se1 = 2'd3} line_state_t;

	// what the core drives onto one port.
	typedef struct packed {logic vp; logic vm; logic oe_n;} pad_out_t;

	// raw pin values of one port.
	typedef struct packed {logic vp; logic vm;} pad_in_t;

	// the single transmit line that the serializer shares with all ports.
	typedef struct packed {logic vp; logic vm; logic oe;} line_drive_t;

endpackage

`default_nettype wire

//--- hdl/usb_link_pkg.sv
// ########################################
// usb link package.
// byte stream structs and framing constants
// for the transmit and receive paths.
// ########################################

`default_nettype none

package usb_link_pkg;

	// sync pattern, sent lsb first, which gives kjkjkjkk on the wire.
	localparam logic [7:0] sync_byte = 8'h80;

	// six ones in a row force a stuffed zero.
	localparam int stuff_run = 6;

	// transmit request from the caller.
	// eop forces the end of packet at the next byte boundary.
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       low_speed;
		logic       eop;
	} tx_ctrl_t;

	// received byte, valid pulses once per byte while active is high.
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       active;
	} rx_byte_t;

endpackage

`default_nettype wire

//--- hdl/usb_port_frontend.sv
// ########################################
// usb port front end.
// pin synchronizer, line state, se0 disconnect
// timer and registered pad drive of one port.
// ########################################

`timescale 1ns/1ps
`default_nettype none

module usb_port_frontend (
	input  logic                      usb_clk,
	input  logic                      usb_rst,
	input  usb_line_pkg::pad_in_t     pad_in,
	input  usb_line_pkg::line_drive_t drive,
	input  logic                      tx_enable,
	input  logic                      low_speed,
	output usb_line_pkg::pad_out_t    pad_out,
	output logic                      speed_full,
	output usb_line_pkg::line_state_t line_state,
	output logic                      discon
);

	usb_line_pkg::pad_in_t meta;
	usb_line_pkg::discon_cnt_t se0_cnt;
	logic oe_n_q;
	logic vp_q;
	logic vm_q;

	// ########################################
	// receive side
	// ########################################

	// two flop synchronizer, the second stage is the line state itself.
	always_ff @(posedge usb_clk) begin
		meta <= pad_in;
		line_state <= usb_line_pkg::line_state_t'({meta.vm, meta.vp});
	end

	// the counter saturates at the limit, so the flag holds while se0 lasts.
	assign discon = (se0_cnt == usb_line_pkg::discon_cnt_t'(usb_line_pkg::discon_limit));

	// any non se0 sample restarts the count.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			se0_cnt <= '0;
		end else if (line_state != usb_line_pkg::se0) begin
			se0_cnt <= '0;
		end else if (!discon) begin
			se0_cnt <= se0_cnt + 1'b1;
		end
	end

	// ########################################
	// transmit side
	// ########################################

	// the port only drives while it is selected and the serializer is active.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			oe_n_q <= 1'b1;
		end else begin
			oe_n_q <= ~(drive.oe & tx_enable);
		end
	end

	// a deselected port keeps its last pin values.
	always_ff @(posedge usb_clk) begin
		if (tx_enable) begin
			vp_q <= drive.vp;
			vm_q <= drive.vm;
		end
	end

	assign pad_out = '{vp: vp_q, vm: vm_q, oe_n: oe_n_q};

	// speed select pin of the transceiver, high for full speed.
	assign speed_full = ~low_speed;

endmodule

`default_nettype wire

//--- hdl/usb_tx_serializer.sv
// ########################################
// usb transmit serializer.
// sends sync, bit stuffed nrzi data and eop
// at full or low speed from a byte stream.
// ########################################

`timescale 1ns/1ps
`default_nettype none

module usb_tx_serializer (
	input  logic                      usb_clk,
	input  logic                      usb_rst,
	input  usb_link_pkg::tx_ctrl_t    tx,
	output logic                      tx_ready,
	output usb_line_pkg::line_drive_t drive
);

	typedef enum logic [1:0] {st_idle, st_sync, st_data, st_eop} state_t;

	state_t state;
	usb_line_pkg::bit_timer_t timer;
	usb_line_pkg::bit_timer_t reload;
	logic low_speed_q;
	logic [7:0] sr;
	logic [2:0] bit_idx;
	logic [2:0] ones;
	logic [1:0] eop_cnt;
	logic eop_req;
	logic level;
	logic stuff;
	logic take;
	logic bit_val;
	logic new_level;

	// the speed is latched when the packet starts.
	assign reload = low_speed_q ? usb_line_pkg::bit_timer_t'(usb_line_pkg::ls_bit_cycles - 1)
		: usb_line_pkg::bit_timer_t'(usb_line_pkg::fs_bit_cycles - 1);

	// a stuffed zero takes priority over the next data bit.
	assign stuff = (ones == 3'(usb_link_pkg::stuff_run));
	assign take = !stuff && (bit_idx == 3'd0) && tx.valid && !tx.eop && !eop_req;

	always_comb begin
		if (stuff) begin
			bit_val = 1'b0;
		end else if (bit_idx == 3'd0) begin
			bit_val = tx.data[0];
		end else begin
			bit_val = sr[0];
		end
	end

	// nrzi, a zero toggles the line and a one holds it.
	assign new_level = bit_val ? level : ~level;

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state <= st_idle;
			timer <= '0;
			low_speed_q <= 1'b0;
			bit_idx <= 3'd0;
			ones <= 3'd0;
			eop_cnt <= 2'd0;
			eop_req <= 1'b0;
			level <= 1'b1;
			tx_ready <= 1'b0;
			drive <= '{vp: 1'b1, vm: 1'b0, oe: 1'b0};
		end else begin
			tx_ready <= 1'b0;
			if (state == st_idle) begin
				eop_req <= 1'b0;
				// the first sync bit goes out together with oe, starting from j.
				if (tx.valid) begin
					state <= st_sync;
					low_speed_q <= tx.low_speed;
					timer <= tx.low_speed
						? usb_line_pkg::bit_timer_t'(usb_line_pkg::ls_bit_cycles - 1)
						: usb_line_pkg::bit_timer_t'(usb_line_pkg::fs_bit_cycles - 1);
					sr <= usb_link_pkg::sync_byte >> 1;
					bit_idx <= 3'd1;
					ones <= {2'b00, usb_link_pkg::sync_byte[0]};
					level <= usb_link_pkg::sync_byte[0];
					drive <= '{vp: usb_link_pkg::sync_byte[0],
						vm: ~usb_link_pkg::sync_byte[0], oe: 1'b1};
				end
			end else begin
				eop_req <= eop_req | tx.eop;
				if (timer != '0) begin
					timer <= timer - 1'b1;
				end else begin
					timer <= reload;
					if (state == st_eop) begin
						// two bit times of se0, one of j, then release the line.
						eop_cnt <= eop_cnt + 2'd1;
						if (eop_cnt == 2'd1) begin
							level <= 1'b1;
							drive <= '{vp: 1'b1, vm: 1'b0, oe: 1'b1};
						end else if (eop_cnt == 2'd2) begin
							state <= st_idle;
							drive <= '{vp: 1'b1, vm: 1'b0, oe: 1'b0};
						end
					end else if (!stuff && (bit_idx == 3'd0) && !take) begin
						// nothing more to send at a byte boundary.
						state <= st_eop;
						eop_cnt <= 2'd0;
						drive <= '{vp: 1'b0, vm: 1'b0, oe: 1'b1};
					end else begin
						if (stuff) begin
							ones <= 3'd0;
						end else begin
							ones <= bit_val ? ones + 3'd1 : 3'd0;
							bit_idx <= bit_idx + 3'd1;
							sr <= take ? tx.data >> 1 : sr >> 1;
						end
						if (take) begin
							state <= st_data;
							tx_ready <= 1'b1;
						end
						level <= new_level;
						drive <= '{vp: new_level, vm: ~new_level, oe: 1'b1};
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/usb_rx_deserializer.sv
// ########################################
// usb receive deserializer.
// picks one port, blanks while transmitting,
// recovers bits and assembles bytes.
// ########################################

`timescale 1ns/1ps
`default_nettype none

module usb_rx_deserializer (
	input  logic                                usb_clk,
	input  logic                                usb_rst,
	input  usb_line_pkg::line_state_t           line_states [usb_line_pkg::num_ports],
	input  logic                                port_sel_rx,
	input  logic [usb_line_pkg::num_ports-1:0]  low_speed,
	input  logic                                tx_oe,
	output usb_link_pkg::rx_byte_t              rx
);

	logic [usb_line_pkg::rx_blank_cycles-1:0] oe_dly;
	logic rx_reset;
	usb_line_pkg::line_state_t cur;
	usb_line_pkg::line_state_t prev;
	logic low;
	usb_line_pkg::bit_timer_t timer;
	usb_line_pkg::bit_timer_t half;
	usb_line_pkg::bit_timer_t full;
	logic sample;
	logic lvl;
	logic last_lvl;
	logic d;
	logic [7:0] sr;
	logic [7:0] shifted;
	logic [2:0] bit_cnt;
	logic [2:0] ones;
	logic [7:0] data_q;
	logic valid_q;
	logic active_q;

	// ########################################
	// port select and blanking
	// ########################################

	assign cur = line_states[port_sel_rx];
	assign low = low_speed[port_sel_rx];

	// our own transmission echoes back on the pins, so the receiver sleeps meanwhile.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			oe_dly <= '0;
		end else begin
			oe_dly <= {oe_dly[usb_line_pkg::rx_blank_cycles-2:0], tx_oe};
		end
	end

	assign rx_reset = usb_rst | oe_dly[usb_line_pkg::rx_blank_cycles-1];

	// ########################################
	// bit recovery
	// ########################################

	assign full = low ? usb_line_pkg::bit_timer_t'(usb_line_pkg::ls_bit_cycles - 1)
		: usb_line_pkg::bit_timer_t'(usb_line_pkg::fs_bit_cycles - 1);
	assign half = low ? usb_line_pkg::bit_timer_t'(usb_line_pkg::ls_bit_cycles / 2 - 1)
		: usb_line_pkg::bit_timer_t'(usb_line_pkg::fs_bit_cycles / 2 - 1);

	always_ff @(posedge usb_clk) begin
		prev <= cur;
	end

	// every transition realigns the sample point to the middle of the bit.
	always_ff @(posedge usb_clk) begin
		if (rx_reset) begin
			timer <= '0;
		end else if (cur != prev) begin
			timer <= half;
		end else if (timer == '0) begin
			timer <= full;
		end else begin
			timer <= timer - 1'b1;
		end
	end

	assign sample = (cur == prev) && (timer == '0);

	// nrzi decode works on either polarity, since only a change of level matters.
	assign lvl = (cur == usb_line_pkg::j_fs);
	assign d = (lvl == last_lvl);
	assign shifted = {d, sr[7:1]};

	// ########################################
	// sync hunt, destuffing and bytes
	// ########################################

	always_ff @(posedge usb_clk) begin
		if (rx_reset) begin
			last_lvl <= 1'b1;
			sr <= 8'hff;
			bit_cnt <= 3'd0;
			ones <= 3'd0;
			valid_q <= 1'b0;
			active_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (sample && (cur == usb_line_pkg::se0)) begin
				// the sync hunt starts again from all ones after the end of packet.
				active_q <= 1'b0;
				sr <= 8'hff;
			end else if (sample && (cur != usb_line_pkg::se1)) begin
				last_lvl <= lvl;
				if (!active_q) begin
					// idle j decodes as ones, so only a real sync can match here.
					sr <= shifted;
					if (shifted == usb_link_pkg::sync_byte) begin
						active_q <= 1'b1;
						bit_cnt <= 3'd0;
						ones <= {2'b00, usb_link_pkg::sync_byte[7]};
					end
				end else if (ones == 3'(usb_link_pkg::stuff_run)) begin
					ones <= 3'd0;
				end else begin
					ones <= d ? ones + 3'd1 : 3'd0;
					sr <= shifted;
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						data_q <= shifted;
						valid_q <= 1'b1;
					end
				end
			end
		end
	end

	assign rx = '{data: data_q, valid: valid_q, active: active_q};

endmodule

`default_nettype wire

//--- hdl/usb_dual_phy.sv
// ########################################
// usb dual port phy top level.
// one shared serializer, one front end per
// port and one receive deserializer.
// ########################################

`timescale 1ns/1ps
`default_nettype none

module usb_dual_phy (
	input  logic                               usb_clk,
	input  logic                               usb_rst,
	input  usb_line_pkg::pad_in_t              pad_in [usb_line_pkg::num_ports],
	output usb_line_pkg::pad_out_t             pad_out [usb_line_pkg::num_ports],
	output logic [usb_line_pkg::num_ports-1:0] speed_full,
	output usb_line_pkg::line_state_t          line_state [usb_line_pkg::num_ports],
	output logic [usb_line_pkg::num_ports-1:0] discon,
	input  logic                               port_sel_rx,
	input  logic [usb_line_pkg::num_ports-1:0] port_sel_tx,
	input  logic [usb_line_pkg::num_ports-1:0] low_speed,
	input  usb_link_pkg::tx_ctrl_t             tx,
	output logic                               tx_ready,
	output usb_link_pkg::rx_byte_t             rx
);

	// the transmit line goes to every port, port_sel_tx decides who drives it.
	usb_line_pkg::line_drive_t drive;

	usb_tx_serializer u_tx (
		.usb_clk (usb_clk),
		.usb_rst (usb_rst),
		.tx      (tx),
		.tx_ready(tx_ready),
		.drive   (drive)
	);

	for (genvar i = 0; i < usb_line_pkg::num_ports; i++) begin : g_port
		usb_port_frontend u_frontend (
			.usb_clk   (usb_clk),
			.usb_rst   (usb_rst),
			.pad_in    (pad_in[i]),
			.drive     (drive),
			.tx_enable (port_sel_tx[i]),
			.low_speed (low_speed[i]),
			.pad_out   (pad_out[i]),
			.speed_full(speed_full[i]),
			.line_state(line_state[i]),
			.discon    (discon[i])
		);
	end

	usb_rx_deserializer u_rx (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.line_states(line_state),
		.port_sel_rx(port_sel_rx),
		.low_speed  (low_speed),
		.tx_oe      (drive.oe),
		.rx         (rx)
	);

endmodule

`default_nettype wire

//--- verif/usb_dual_phy_assert.sv
// ########################################
// usb dual phy assertions.
// protocol rules on the top level ports.
// ########################################

`timescale 1ns/1ps
`default_nettype none

module usb_dual_phy_assert (
	input logic                               usb_clk,
	input logic                               usb_rst,
	input usb_line_pkg::pad_out_t             pad_out [usb_line_pkg::num_ports],
	input logic [usb_line_pkg::num_ports-1:0] port_sel_tx,
	input logic [usb_line_pkg::num_ports-1:0] discon,
	input usb_line_pkg::line_state_t          line_state [usb_line_pkg::num_ports],
	input logic                               tx_ready,
	input usb_link_pkg::rx_byte_t             rx
);

	for (genvar i = 0; i < usb_line_pkg::num_ports; i++) begin : g_port
		// the pad register follows the port select one cycle later.
		deselected_off: assert property (@(posedge usb_clk) disable iff (usb_rst)
			!port_sel_tx[i] |=> pad_out[i].oe_n)
			else $error("port %0d drives while deselected", i);
		// the flag lags the line state by one cycle.
		discon_on_se0: assert property (@(posedge usb_clk) disable iff (usb_rst)
			discon[i] |-> ($past(line_state[i]) == usb_line_pkg::se0))
			else $error("port %0d flags a disconnect without se0", i);
	end

	valid_in_packet: assert property (@(posedge usb_clk) disable iff (usb_rst)
		rx.valid |-> rx.active)
		else $error("rx valid outside of a packet");

	ready_single: assert property (@(posedge usb_clk) disable iff (usb_rst)
		tx_ready |=> !tx_ready)
		else $error("tx_ready high on two cycles in a row");

endmodule

bind usb_dual_phy usb_dual_phy_assert u_assert (
	.usb_clk    (usb_clk),
	.usb_rst    (usb_rst),
	.pad_out    (pad_out),
	.port_sel_tx(port_sel_tx),
	.discon     (discon),
	.line_state (line_state),
	.tx_ready   (tx_ready),
	.rx         (rx)
);

`default_nettype wire

//--- verif/usb_dual_phy_tb.sv
// ########################################
// usb dual phy testbench.
// random packets out and in, se0 disconnect runs,
// checked against a line encoder model.
// ########################################

`timescale 1ns/1ps
`default_nettype none

module usb_dual_phy_tb;

	localparam int np = usb_line_pkg::num_ports;
	// a worst case low speed packet has sync, eight stuffed bytes and eop.
	localparam int pkt_cycles = (8 + 8 * 8 * 7 / 6 + 4) * usb_line_pkg::ls_bit_cycles;
	localparam int max_cycles = 6 * pkt_cycles + 5 * 250 + 2000;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;
	localparam logic [1:0] sym_j = 2'b01;
	localparam logic [1:0] sym_k = 2'b10;
	localparam logic [1:0] sym_se0 = 2'b00;

	logic usb_clk;
	logic usb_rst;
	usb_line_pkg::pad_in_t pad_in [np];
	usb_line_pkg::pad_out_t pad_out [np];
	logic [np-1:0] speed_full;
	usb_line_pkg::line_state_t line_state [np];
	logic [np-1:0] discon;
	logic port_sel_rx;
	logic [np-1:0] port_sel_tx;
	logic [np-1:0] low_speed;
	usb_link_pkg::tx_ctrl_t tx;
	logic tx_ready;
	usb_link_pkg::rx_byte_t rx;

	logic [31:0] lfsr;
	int cycles;
	int settle;
	int se0_run [np];
	usb_line_pkg::pad_in_t pin_now [np];
	usb_line_pkg::pad_in_t pin_prev [np];
	logic discon_seen;
	logic [1:0] sym_q [$];
	logic [7:0] pkt [$];
	logic [7:0] got [$];

	usb_dual_phy dut (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.pad_in     (pad_in),
		.pad_out    (pad_out),
		.speed_full (speed_full),
		.line_state (line_state),
		.discon     (discon),
		.port_sel_rx(port_sel_rx),
		.port_sel_tx(port_sel_tx),
		.low_speed  (low_speed),
		.tx         (tx),
		.tx_ready   (tx_ready),
		.rx         (rx)
	);

	initial begin
		usb_clk = 1'b0;
		forever #50 usb_clk = ~usb_clk;
	end

	// galois lfsr that steps once for every bit handed out.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	// ########################################
	// line encoder model
	// ########################################

	// in nrzi a zero toggles the level, and six ones in a row add a stuffed zero.
	task automatic push_bit(input logic b, inout logic level, inout int ones);
		if (!b) begin
			level = ~level;
		end
		sym_q.push_back(level ? sym_j : sym_k);
		ones = b ? ones + 1 : 0;
		if (ones == usb_link_pkg::stuff_run) begin
			level = ~level;
			sym_q.push_back(level ? sym_j : sym_k);
			ones = 0;
		end
	endtask

	// turns pkt into one {vm, vp} line symbol per bit time, starting from idle j.
	task automatic encode_packet();
		logic level;
		int ones;
		logic [7:0] b;
		sym_q.delete();
		level = 1'b1;
		ones = 0;
		for (int i = 0; i <= pkt.size(); i++) begin
			b = (i == 0) ? 8'h80 : pkt[i-1];
			for (int k = 0; k < 8; k++) begin
				push_bit(b[k], level, ones);
			end
		end
		sym_q.push_back(sym_se0);
		sym_q.push_back(sym_se0);
		sym_q.push_back(sym_j);
	endtask

	// ########################################
	// monitors
	// ########################################

	// pins are sampled on the rising edge, and settle counts the cycles since reset.
	always @(posedge usb_clk) begin
		cycles++;
		if (cycles > max_cycles) begin
			abort_run("timeout: the tests did not finish within the cycle limit");
		end
		for (int p = 0; p < np; p++) begin
			pin_prev[p] = pin_now[p];
			pin_now[p] = pad_in[p];
		end
		settle = usb_rst ? 0 : ((settle < 3) ? settle + 1 : 3);
	end

	always @(negedge usb_clk) begin
		if (rx.valid) begin
			got.push_back(rx.data);
		end
		for (int p = 0; p < np; p++) begin
			if (settle == 3) begin
				assert (line_state[p] == usb_line_pkg::line_state_t'({pin_prev[p].vm,
					pin_prev[p].vp})) else
					abort_run($sformatf("mismatch at %0t ns: port %0d line state %b",
						$time, p, line_state[p]));
				assert (discon[p] == (se0_run[p] == usb_line_pkg::discon_limit)) else
					abort_run($sformatf("mismatch at %0t ns: port %0d discon %b after %0d se0",
						$time, p, discon[p], se0_run[p]));
			end
			discon_seen |= discon[p];
			// the next posedge counts the line state seen now.
			if (settle == 0 || line_state[p] != usb_line_pkg::se0) begin
				se0_run[p] = 0;
			end else if (se0_run[p] < usb_line_pkg::discon_limit) begin
				se0_run[p]++;
			end
		end
	end

	// ########################################
	// test tasks
	// ########################################

	task automatic check_pins(input logic [np-1:0] sel, input logic on, input logic [1:0] sym);
		for (int p = 0; p < np; p++) begin
			if (sel[p] && on) begin
				assert (!pad_out[p].oe_n && {pad_out[p].vm, pad_out[p].vp} == sym) else
					abort_run($sformatf("mismatch at %0t ns: port %0d pins %b, expected %b",
						$time, p, pad_out[p], sym));
			end else if (!sel[p]) begin
				assert (pad_out[p].oe_n) else
					abort_run($sformatf("mismatch at %0t ns: deselected port %0d drives",
						$time, p));
			end
		end
	endtask

	// sends one packet and checks every bit time on every port.
	task automatic send_packet(input logic low);
		int n;
		int bc;
		int watch;
		int idx;
		int lead;
		logic [np-1:0] sel;
		n = 1 + int'(take_bits(3));
		pkt.delete();
		// at low speed the first byte is always all ones, so stuffing is exercised.
		for (int i = 0; i < n; i++) begin
			pkt.push_back((low && (i == 0 || take_bits(1))) ? 8'hff : 8'(take_bits(8)));
		end
		sel = '0;
		while (sel == '0) begin
			sel = np'(take_bits(np));
		end
		watch = sel[0] ? 0 : 1;
		bc = low ? usb_line_pkg::ls_bit_cycles : usb_line_pkg::fs_bit_cycles;
		encode_packet();
		@(negedge usb_clk);
		port_sel_tx = sel;
		tx = '{data: pkt[0], valid: 1'b1, low_speed: low, eop: 1'b0};
		fork
			begin
				idx = 0;
				while (tx.valid) begin
					@(negedge usb_clk);
					if (tx_ready) begin
						idx++;
						if (idx < n) begin
							tx.data = pkt[idx];
						end else begin
							tx.valid = 1'b0;
						end
					end
				end
			end
			begin
				lead = 0;
				while (pad_out[watch].oe_n) begin
					@(negedge usb_clk);
					lead++;
					check_pins(sel, 1'b0, sym_j);
				end
				// oe rises one cycle after valid and reaches the pins one cycle later.
				assert (lead == 2) else
					abort_run($sformatf("mismatch at %0t ns: pins enabled %0d cycles after valid",
						$time, lead));
				foreach (sym_q[s]) begin
					for (int c = 0; c < bc; c++) begin
						if (s != 0 || c != 0) begin
							@(negedge usb_clk);
						end
						check_pins(sel, 1'b1, sym_q[s]);
					end
				end
				@(negedge usb_clk);
				for (int p = 0; p < np; p++) begin
					assert (pad_out[p].oe_n) else
						abort_run("a port kept driving after the end of packet");
				end
			end
		join
	endtask

	// encodes a packet onto the selected port while the other port carries noise.
	task automatic receive_packet();
		int n;
		int bc;
		int p;
		n = 1 + int'(take_bits(3));
		pkt.delete();
		for (int i = 0; i < n; i++) begin
			pkt.push_back(take_bits(1) ? 8'hff : 8'(take_bits(8)));
		end
		@(negedge usb_clk);
		port_sel_tx = '0;
		port_sel_rx = 1'(take_bits(1));
		low_speed = np'(take_bits(np));
		p = int'(port_sel_rx);
		bc = low_speed[p] ? usb_line_pkg::ls_bit_cycles : usb_line_pkg::fs_bit_cycles;
		encode_packet();
		@(negedge usb_clk);
		assert (speed_full == ~low_speed) else
			abort_run($sformatf("mismatch at %0t ns: speed_full %b", $time, speed_full));
		repeat (4 * bc) @(negedge usb_clk);
		got.delete();
		foreach (sym_q[s]) begin
			repeat (bc) begin
				pad_in[p] = '{vp: sym_q[s][0], vm: sym_q[s][1]};
				if (take_bits(1)) begin
					pad_in[1-p] = '{vp: 1'b1, vm: 1'b0};
				end else begin
					pad_in[1-p] = '{vp: 1'b0, vm: 1'b1};
				end
				@(negedge usb_clk);
			end
		end
		pad_in[1-p] = '{vp: 1'b1, vm: 1'b0};
		repeat (8 * bc) @(negedge usb_clk);
		assert (!rx.active) else abort_run("receiver still active after the end of packet");
		assert (got.size() == n) else
			abort_run($sformatf("mismatch at %0t ns: %0d bytes received, %0d sent",
				$time, got.size(), n));
		foreach (pkt[i]) begin
			assert (got[i] == pkt[i]) else
				abort_run($sformatf("mismatch at %0t ns: byte %0d is %h, expected %h",
					$time, i, got[i], pkt[i]));
		end
	endtask

	task automatic drive_se0(input int len);
		int p;
		p = int'(take_bits(1));
		@(negedge usb_clk);
		pad_in[p] = '{vp: 1'b0, vm: 1'b0};
		repeat (len) @(negedge usb_clk);
		pad_in[p] = '{vp: 1'b1, vm: 1'b0};
		repeat (10) @(negedge usb_clk);
	endtask

	initial begin
		lfsr = 32'h1b85;
		usb_rst = 1'b1;
		port_sel_rx = 1'b0;
		port_sel_tx = '0;
		low_speed = '0;
		tx = '0;
		discon_seen = 1'b0;
		for (int p = 0; p < np; p++) begin
			pad_in[p] = '{vp: 1'b1, vm: 1'b0};
		end
		repeat (8) @(posedge usb_clk);
		@(negedge usb_clk);
		usb_rst = 1'b0;
		@(negedge usb_clk);
		assert (!tx_ready && !rx.valid && !rx.active && discon == '0) else
			abort_run("outputs are not inactive after reset");
		for (int p = 0; p < np; p++) begin
			assert (pad_out[p].oe_n) else abort_run("a port drives right after reset");
		end
		send_packet(1'b0);
		send_packet(1'b0);
		send_packet(1'b1);
		receive_packet();
		receive_packet();
		receive_packet();
		for (int i = 0; i < 4; i++) begin
			drive_se0(100 + int'(take_bits(7)));
		end
		drive_se0(140);
		assert (discon_seen) else abort_run("no disconnect was flagged during the se0 runs");
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- usb_dual_phy.f
hdl/usb_line_pkg.sv
hdl/usb_link_pkg.sv
hdl/usb_port_frontend.sv
hdl/usb_tx_serializer.sv
hdl/usb_rx_deserializer.sv
hdl/usb_dual_phy.sv
verif/usb_dual_phy_assert.sv
verif/usb_dual_phy_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the usb dual phy testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module usb_dual_phy_tb -f usb_dual_phy.f -o usb_dual_phy_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/usb_dual_phy_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
